/* list.f */
verilog/cpu_pkg.sv
verilog/cpu_ctrl_if.sv
verilog/cpu_alu.sv
verilog/cpu_regfile.sv
verilog/cpu_control.sv
verilog/cpu_datapath.sv
verilog/cpu_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* tests/tb_checker.sv */
`timescale 1ns/10ps

module tb_checker #(
    parameter logic [31:0] RESET_VECTOR = '0,
    parameter int          MEM_WORDS    = 1024
) (
    input logic        clk_i,
    input logic        rst_i,
    input logic        bus_cyc,
    input logic        bus_write,
    input logic [31:0] bus_adr,
    input logic [31:0] bus_dat_w,
    input logic        bus_ack,
    input logic        halt
);

    logic [31:0] mem [MEM_WORDS]; // program and data copy, written by tb_top
    logic [31:0] regs [16];
    logic [31:0] pc;
    logic        f_ltu;
    logic        f_lt;
    logic        f_eq;
    logic        halted;
    logic        started;
    logic        load_pending;
    logic [31:0] load_adr;
    logic [31:0] st_adr_q [$];
    logic [31:0] st_dat_q [$];
    int          error_count = 0;

    function automatic logic taken(input logic [3:0] c);
        case (c)
            4'd0:    return 1'b1;               // bra
            4'd1:    return f_eq;
            4'd2:    return !f_eq;
            4'd3:    return !(f_ltu || f_eq);   // bgtu
            4'd4:    return !(f_lt || f_eq);    // bgt
            4'd5:    return !f_lt;
            4'd6:    return f_lt || f_eq;
            4'd7:    return f_lt;
            4'd8:    return !f_ltu;
            4'd9:    return f_ltu;
            4'd10:   return f_ltu || f_eq;
            default: return 1'b0;               // brn and unused codes
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f)
            3'd0:    return a + b;
            3'd1:    return a - b;
            3'd2:    return a & b;
            3'd3:    return a | b;
            3'd4:    return a ^ b;
            3'd5:    return a << b[4:0];
            3'd6:    return a >> b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    task automatic step_model();
        logic [31:0] ir;
        logic [31:0] sval;
        logic [31:0] adr;
        logic [31:0] b;
        ir   = mem[pc[11:2]];
        sval = {{17{ir[15]}}, ir[15:1]};
        pc   = pc + 32'd4;
        case (ir[31:28])
            4'h0: ;
            4'ha: regs[ir[23:20]] = {17'h0, ir[15:1]};
            4'h4: regs[ir[23:20]] = regs[ir[19:16]];
            4'h3: begin
                f_ltu = regs[ir[23:20]] < regs[ir[19:16]];
                f_lt  = $signed(regs[ir[23:20]]) < $signed(regs[ir[19:16]]);
                f_eq  = regs[ir[23:20]] == regs[ir[19:16]];
            end
            4'h9: begin
                b = ir[27] ? sval : regs[ir[15:12]];
                regs[ir[23:20]] = alu_model(ir[26:24], regs[ir[19:16]], b);
            end
            4'hb: begin
                adr              = regs[ir[19:16]] + sval;
                regs[ir[23:20]]  = mem[adr[11:2]];
                load_pending     = 1'b1;
                load_adr         = adr;
            end
            4'hc: begin
                adr = regs[ir[19:16]] + sval;
                st_adr_q.push_back(adr);
                st_dat_q.push_back(regs[ir[23:20]]);
                mem[adr[11:2]] = regs[ir[23:20]];
            end
            4'hd: if (taken(ir[27:24])) pc = pc + {sval[29:0], 2'b00};
            default: halted = 1'b1;
        endcase
    endtask

    always @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc           = RESET_VECTOR;
            {f_ltu, f_lt, f_eq} = 3'b000;
            halted       = 1'b0;
            started      = 1'b0;
            load_pending = 1'b0;
            st_adr_q.delete();
            st_dat_q.delete();
            for (int i = 0; i < 16; i++) regs[i] = '0;
        end else begin
            if (!started) begin
                started = 1'b1;
                if (bus_write || halt) begin
                    $display("After reset bus_write or halt is not low at %0t", $time);
                    error_count++;
                end
            end
            if (halt && !halted) begin
                $display("Halt raised at %0t before any undefined instruction", $time);
                error_count++;
            end
            if (halt && bus_cyc) begin
                $display("Bus cycle started after halt at %0t", $time);
                error_count++;
            end
            if (bus_cyc && bus_ack && bus_write) begin
                if (st_adr_q.size() == 0) begin
                    $display("Mismatch at %0t: unexpected store to %h", $time, bus_adr);
                    error_count++;
                end else if (bus_adr !== st_adr_q[0] || bus_dat_w !== st_dat_q[0]) begin
                    $display("Mismatch at %0t: store %h <= %h, expected %h <= %h", $time,
                             bus_adr, bus_dat_w, st_adr_q[0], st_dat_q[0]);
                    error_count++;
                end
                if (st_adr_q.size() != 0) begin
                    void'(st_adr_q.pop_front());
                    void'(st_dat_q.pop_front());
                end
            end else if (bus_cyc && bus_ack) begin
                if (load_pending) begin
                    if (bus_adr !== load_adr) begin
                        $display("Mismatch at %0t: read at %h, expected load at %h", $time,
                                 bus_adr, load_adr);
                        error_count++;
                    end
                    load_pending = 1'b0;
                end else if (!halted && bus_adr == pc) begin
                    step_model();
                end else begin
                    $display("Mismatch at %0t: read at %h, expected fetch at %h", $time,
                             bus_adr, pc);
                    error_count++;
                end
            end
        end
    end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

    localparam int          NUM_TESTS    = 24;
    localparam int          PROG_LEN     = 48;
    localparam int          MEM_WORDS    = 1024;
    localparam logic [31:0] RESET_VECTOR = 32'h0;

    logic        clk_i;
    logic        rst_i;
    logic        bus_cyc;
    logic        bus_write;
    logic [31:0] bus_adr;
    logic [31:0] bus_dat_w;
    logic [31:0] bus_dat_r;
    logic        bus_ack;
    logic        halt;
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog_seed = 32'ha735d074;
    logic [31:0] bus_seed  = 32'ha735d074 ^ 32'h1;
    logic [1:0]  wait_cnt;
    int          errs_before;

    cpu_top #(.RESET_VECTOR(RESET_VECTOR), .SHIFT_WIDTH(5)) u_dut (
        .clk_i(clk_i), .rst_i(rst_i), .bus_cyc(bus_cyc), .bus_write(bus_write),
        .bus_adr(bus_adr), .bus_dat_w(bus_dat_w), .bus_dat_r(bus_dat_r),
        .bus_ack(bus_ack), .halt(halt)
    );

    tb_checker #(.RESET_VECTOR(RESET_VECTOR), .MEM_WORDS(MEM_WORDS)) u_chk (
        .clk_i(clk_i), .rst_i(rst_i), .bus_cyc(bus_cyc), .bus_write(bus_write),
        .bus_adr(bus_adr), .bus_dat_w(bus_dat_w),
        .bus_ack(bus_ack), .halt(halt)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        prog_seed = lcg_next(prog_seed);
        return prog_seed;
    endfunction

    always #10 clk_i = ~clk_i;

    // memory model, 0 to 3 wait cycles per access
    always @(posedge clk_i) begin
        if (rst_i) begin
            bus_ack  <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (bus_ack) begin
            bus_ack <= 1'b0;
        end else if (bus_cyc && wait_cnt == 2'd0) begin
            bus_ack <= 1'b1;
            if (bus_write)
                mem[bus_adr[11:2]] <= bus_dat_w;
            else
                bus_dat_r <= mem[bus_adr[11:2]];
        end else if (bus_cyc) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            bus_seed = lcg_next(bus_seed);
            wait_cnt <= bus_seed[31:30];
        end
    end

    task automatic make_program();
        logic [31:0] r;
        logic [3:0]  bra_op [PROG_LEN];
        logic [1:0]  bra_off [PROG_LEN];
        logic        is_bra [PROG_LEN+4];
        logic        pair2 [PROG_LEN+4];
        int          i;
        int          t;
        for (int k = 0; k < MEM_WORDS; k++)
            mem[k] = (k * 32'h9e3779b1) ^ {k[15:0], ~k[15:0]}; // data fill per address
        for (int k = 0; k < PROG_LEN + 4; k++) begin
            mem[k]    = {(k % 2) ? 4'h1 : 4'hf, 28'h0}; // undefined types halt
            is_bra[k] = 1'b0;
            pair2[k]  = 1'b0;
        end
        i = 0;
        while (i < PROG_LEN - 1) begin
            r = next_rand();
            case (r[31:29])
                3'd0: mem[i] = {4'h0, r[27:0]};
                3'd1: mem[i] = {4'ha, r[27:0]};
                3'd2: mem[i] = {4'h4, r[27:0]};
                3'd5: begin // cmp, then a branch
                    mem[i] = {4'h3, r[27:0]};
                    if (i < PROG_LEN - 2) begin
                        i++;
                        is_bra[i]  = 1'b1;
                        bra_op[i]  = r[11:8];
                        bra_off[i] = r[7:6] % 3;
                    end
                end
                3'd6, 3'd7: begin
                    if (i < PROG_LEN - 2) begin
                        mem[i] = {4'ha, 4'h0, r[19:16], 4'h0, 15'h400 + {r[4:0], 2'b00}, 1'b0};
                        i++;
                        pair2[i] = 1'b1;
                        mem[i] = {r[29] ? 4'hb : 4'hc, r[27:20], r[19:16],
                                  10'h0, r[2:0], 2'b00, 1'b0}; // offset 4*j
                    end else begin
                        mem[i] = 32'h0;
                    end
                end
                default: mem[i] = {4'h9, r[27:0]};
            endcase
            i++;
        end
        // keep branches from landing between an ldi and its load or store
        for (int k = 0; k < PROG_LEN; k++) begin
            if (is_bra[k]) begin
                t = k + 1 + bra_off[k];
                if (pair2[t])
                    bra_off[k] = bra_off[k] - 2'd1;
                mem[k] = {4'hd, bra_op[k], 8'h0, 13'h0, bra_off[k], 1'b0};
            end
        end
        for (int k = 0; k < MEM_WORDS; k++)
            u_chk.mem[k] = mem[k];
    endtask

    initial begin
        repeat (NUM_TESTS * (PROG_LEN * 40 + 20)) @(posedge clk_i);
        $display("Watchdog expired, the core did not finish its programs in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        bus_ack   = 1'b0;
        bus_dat_r = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = u_chk.error_count;
            @(posedge clk_i);
            rst_i <= 1'b1;
            make_program();
            repeat (8) @(posedge clk_i);
            rst_i <= 1'b0;
            @(posedge clk_i);
            while (!halt) @(posedge clk_i);
            repeat (6) @(posedge clk_i); // checker watches for stray bus cycles
            @(negedge clk_i);
            $display("test %0d finished with %0d errors", t, u_chk.error_count - errs_before);
        end
        $display("%0d tests run, %0d errors", NUM_TESTS, u_chk.error_count);
        if (u_chk.error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog/cpu_alu.sv */
`timescale 1ns/10ps

module cpu_alu import cpu_pkg::*; #(
    parameter int SHIFT_WIDTH = 5
) (
    input  word_t      a,
    input  word_t      b,
    input  alu_func_e  func,
    output word_t      result,
    output logic [2:0] flags
);

    logic [SHIFT_WIDTH-1:0] shamt;
    logic [32:0]            diff;
    logic                   ltu;
    logic                   lt;
    logic                   eq;

    assign shamt = b[SHIFT_WIDTH-1:0];
    assign diff  = {1'b0, a} - {1'b0, b};

    assign ltu = diff[32]; // borrow out
    assign lt  = (a[31] != b[31]) ? a[31] : diff[31];
    assign eq  = (diff[31:0] == '0);
    assign flags = {ltu, lt, eq};

    always_comb begin
        case (func)
            alu_add:  result = a + b;
            alu_sub:  result = diff[31:0];
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_shl:  result = a << shamt;
            alu_shr:  result = a >> shamt;
            alu_ashr: result = $signed(a) >>> shamt;
            default:  result = a + b;
        endcase
    end

endmodule

/* verilog/cpu_control.sv */
`timescale 1ns/10ps

module cpu_control import cpu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    cpu_ctrl_if.ctrl ctl,
    output logic     bus_cyc,
    output logic     bus_write,
    input  logic     bus_ack,
    output logic     halt
);

    state_e      state;
    state_e      state_next;
    instr_type_e ir_type;
    logic [3:0]  ir_op;
    reg_addr_t   ir_ra;
    reg_addr_t   ir_rb;
    reg_addr_t   ir_rc;
    logic        ccr_ltu;
    logic        ccr_lt;
    logic        ccr_eq;
    logic        bra_taken;

    assign ir_type = instr_type_e'(ctl.ir[31:28]);
    assign ir_op   = ctl.ir[27:24];
    assign ir_ra   = ctl.ir[23:20];
    assign ir_rb   = ctl.ir[19:16];
    assign ir_rc   = ctl.ir[15:12];
    assign {ccr_ltu, ccr_lt, ccr_eq} = ctl.ccr;

    assign halt = (state == s_halt);

    always_comb begin
        case (bra_cond_e'(ir_op))
            bc_bra:  bra_taken = 1'b1;
            bc_beq:  bra_taken = ccr_eq;
            bc_bne:  bra_taken = ~ccr_eq;
            bc_bgtu: bra_taken = ~(ccr_ltu | ccr_eq);
            bc_bgt:  bra_taken = ~(ccr_lt | ccr_eq);
            bc_bge:  bra_taken = ~ccr_lt;
            bc_ble:  bra_taken = ccr_lt | ccr_eq;
            bc_blt:  bra_taken = ccr_lt;
            bc_bgeu: bra_taken = ~ccr_ltu;
            bc_bltu: bra_taken = ccr_ltu;
            bc_bleu: bra_taken = ccr_ltu | ccr_eq;
            default: bra_taken = 1'b0; // brn and spare codes
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state <= s_reset;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next         = state;
        ctl.ir_write       = 1'b0;
        ctl.a_write        = 1'b0;
        ctl.b_write        = 1'b0;
        ctl.reg_write      = 1'b0;
        ctl.ccr_write      = 1'b0;
        ctl.alu_func       = alu_add;
        ctl.alu2_sel       = alu2_b;
        ctl.reg_sel        = reg_alu;
        ctl.mdr_sel        = mdr_hold;
        ctl.mar_sel        = mar_hold;
        ctl.pc_sel         = pc_hold;
        ctl.addr_sel       = addr_pc;
        ctl.reg_read_addr1 = ir_ra;
        ctl.reg_read_addr2 = ir_rb;
        ctl.reg_write_addr = ir_ra;
        bus_cyc            = 1'b0;
        bus_write          = 1'b0;

        case (state)
            s_reset: state_next = s_fetch;
            s_fetch: begin
                bus_cyc      = 1'b1;
                ctl.ir_write = 1'b1; // ir takes bus data on ack
                if (bus_ack)
                    state_next = s_fetch2;
            end
            s_fetch2: begin
                ctl.pc_sel = pc_next;
                state_next = s_eval;
            end
            s_eval: begin
                case (ir_type)
                    t_inh:    state_next = s_inh;
                    t_ldi:    state_next = s_ldi;
                    t_mov:    state_next = s_mov;
                    t_cmp:    state_next = s_cmp;
                    t_branch: state_next = s_branch;
                    t_alu:    state_next = s_alu;
                    t_load:   state_next = s_load;
                    t_store:  state_next = s_store;
                    default:  state_next = s_halt;
                endcase
            end
            s_inh: state_next = s_fetch; // nop
            s_ldi: begin
                ctl.reg_sel   = reg_imm;
                ctl.reg_write = 1'b1;
                state_next    = s_fetch;
            end
            s_mov: begin
                ctl.b_write = 1'b1; // B <= rB
                state_next  = s_mov2;
            end
            s_mov2: begin
                ctl.reg_sel   = reg_b;
                ctl.reg_write = 1'b1;
                state_next    = s_fetch;
            end
            s_cmp: begin
                ctl.a_write = 1'b1; // A <= rA
                ctl.b_write = 1'b1; // B <= rB
                state_next  = s_cmp2;
            end
            s_cmp2: begin
                ctl.alu_func  = alu_sub;
                ctl.ccr_write = 1'b1;
                state_next    = s_term;
            end
            s_term: state_next = s_fetch;
            s_branch: begin
                if (bra_taken)
                    ctl.pc_sel = pc_rel;
                state_next = s_fetch;
            end
            s_alu: begin
                ctl.reg_read_addr1 = ir_rb;
                ctl.reg_read_addr2 = ir_rc;
                ctl.a_write        = 1'b1;
                ctl.b_write        = 1'b1;
                state_next         = s_alu2;
            end
            s_alu2, s_alu3: begin
                ctl.alu_func = alu_func_e'(ir_op[2:0]);
                ctl.alu2_sel = ir_op[3] ? alu2_sval : alu2_b;
                if (state == s_alu3) begin
                    ctl.mdr_sel = mdr_alu;
                    state_next  = s_mdr2ra;
                end else begin
                    state_next  = s_alu3;
                end
            end
            s_mdr2ra: begin
                ctl.reg_sel   = reg_mdr;
                ctl.reg_write = 1'b1;
                state_next    = s_fetch;
            end
            s_load, s_store: begin
                ctl.reg_read_addr1 = ir_rb;
                ctl.a_write        = 1'b1; // A <= rB
                state_next         = (state == s_load) ? s_load2 : s_store2;
            end
            s_load2: begin
                ctl.alu2_sel = alu2_sval;
                state_next   = s_load3;
            end
            s_load3: begin
                ctl.alu2_sel = alu2_sval;
                ctl.mar_sel  = mar_alu;
                state_next   = s_load4;
            end
            s_load4: begin
                ctl.addr_sel = addr_mar;
                ctl.mdr_sel  = mdr_bus;
                bus_cyc      = 1'b1;
                if (bus_ack)
                    state_next = s_mdr2ra;
            end
            s_store2: begin
                ctl.alu2_sel = alu2_sval;
                ctl.mar_sel  = mar_alu;
                ctl.a_write  = 1'b1; // A <= rA, same edge as MAR
                state_next   = s_store3;
            end
            s_store3: begin
                ctl.mdr_sel = mdr_a;
                state_next  = s_store4;
            end
            s_store4: begin
                ctl.addr_sel = addr_mar;
                bus_cyc      = 1'b1;
                bus_write    = 1'b1;
                if (bus_ack)
                    state_next = s_term;
            end
            s_halt: state_next = s_halt;
            default: state_next = s_halt;
        endcase
    end

    assert property (@(posedge clk_i) disable iff (rst_i) bus_write |-> bus_cyc);

    // only reset leaves halt
    assert property (@(posedge clk_i) disable iff (rst_i) $past(halt) |-> halt);

endmodule

/* verilog/cpu_ctrl_if.sv */
`timescale 1ns/10ps

interface cpu_ctrl_if import cpu_pkg::*; ();

    logic        ir_write;
    logic        a_write;
    logic        b_write;
    logic        reg_write;
    logic        ccr_write;
    alu_func_e   alu_func;
    alu2_sel_e   alu2_sel;
    reg_sel_e    reg_sel;
    mdr_sel_e    mdr_sel;
    mar_sel_e    mar_sel;
    pc_sel_e     pc_sel;
    addr_sel_e   addr_sel;
    reg_addr_t   reg_read_addr1;
    reg_addr_t   reg_read_addr2;
    reg_addr_t   reg_write_addr;
    word_t       ir;
    logic [2:0]  ccr;

    modport ctrl (
        output ir_write, a_write, b_write, reg_write, ccr_write,
        output alu_func, alu2_sel, reg_sel, mdr_sel, mar_sel, pc_sel, addr_sel,
        output reg_read_addr1, reg_read_addr2, reg_write_addr,
        input  ir, ccr
    );

    modport dp (
        input  ir_write, a_write, b_write, reg_write, ccr_write,
        input  alu_func, alu2_sel, reg_sel, mdr_sel, mar_sel, pc_sel, addr_sel,
        input  reg_read_addr1, reg_read_addr2, reg_write_addr,
        output ir, ccr
    );

endinterface

/* verilog/cpu_datapath.sv */
`timescale 1ns/10ps

module cpu_datapath import cpu_pkg::*; #(
    parameter word_t RESET_VECTOR = '0,
    parameter int    SHIFT_WIDTH  = 5
) (
    input  logic   clk_i,
    input  logic   rst_i,
    cpu_ctrl_if.dp ctl,
    output word_t  bus_adr,
    output word_t  bus_dat_w,
    input  word_t  bus_dat_r,
    input  logic   bus_ack
);

    word_t      ir_q;
    word_t      pc_q;
    word_t      a_q;
    word_t      b_q;
    word_t      mar_q;
    word_t      mdr_q;
    logic [2:0] ccr_q;
    word_t      rd1;
    word_t      rd2;
    word_t      alu_b;
    word_t      alu_out;
    logic [2:0] alu_flags;
    word_t      sval;
    word_t      imm;
    word_t      pc_target;
    word_t      reg_wdata;

    assign ctl.ir  = ir_q;
    assign ctl.ccr = ccr_q;

    assign sval      = {{17{ir_q[15]}}, ir_q[15:1]};
    assign imm       = {17'h0, ir_q[15:1]};
    assign pc_target = pc_q + {sval[29:0], 2'b00}; // pc already stepped

    assign bus_adr   = (ctl.addr_sel == addr_mar) ? mar_q : pc_q;
    assign bus_dat_w = mdr_q;

    always_comb begin
        case (ctl.alu2_sel)
            alu2_four: alu_b = 32'd4;
            alu2_sval: alu_b = sval;
            default:   alu_b = b_q;
        endcase
    end

    always_comb begin
        case (ctl.reg_sel)
            reg_b:   reg_wdata = b_q;
            reg_mdr: reg_wdata = mdr_q;
            reg_imm: reg_wdata = imm;
            default: reg_wdata = alu_out;
        endcase
    end

    cpu_alu #(.SHIFT_WIDTH(SHIFT_WIDTH)) u_alu (
        .a      (a_q),
        .b      (alu_b),
        .func   (ctl.alu_func),
        .result (alu_out),
        .flags  (alu_flags)
    );

    cpu_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .read_addr1 (ctl.reg_read_addr1),
        .read_addr2 (ctl.reg_read_addr2),
        .read_data1 (rd1),
        .read_data2 (rd2),
        .write_en   (ctl.reg_write),
        .write_addr (ctl.reg_write_addr),
        .write_data (reg_wdata)
    );

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ir_q  <= '0;
            pc_q  <= RESET_VECTOR;
            ccr_q <= '0;
        end else begin
            if (ctl.ir_write && bus_ack)
                ir_q <= bus_dat_r;
            if (ctl.ccr_write)
                ccr_q <= alu_flags;
            case (ctl.pc_sel)
                pc_next: pc_q <= pc_q + 32'd4;
                pc_rel:  pc_q <= pc_target;
                pc_alu:  pc_q <= alu_out;
                default: pc_q <= pc_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctl.a_write)
            a_q <= rd1;
        if (ctl.b_write)
            b_q <= rd2;
        if (ctl.mar_sel == mar_alu)
            mar_q <= alu_out;
        case (ctl.mdr_sel)
            mdr_bus: if (bus_ack) mdr_q <= bus_dat_r; // capture on ack edge
            mdr_alu: mdr_q <= alu_out;
            mdr_a:   mdr_q <= a_q;
            default: mdr_q <= mdr_q;
        endcase
    end

    // an ack must belong to exactly one bus consumer
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(bus_ack && ctl.ir_write && ctl.mdr_sel == mdr_bus));

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // instruction word bits 31..28
    typedef enum logic [3:0] {
        t_inh    = 4'h0,
        t_cmp    = 4'h3,
        t_mov    = 4'h4,
        t_alu    = 4'h9,
        t_ldi    = 4'ha,
        t_load   = 4'hb,
        t_store  = 4'hc,
        t_branch = 4'hd
    } instr_type_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_shr, alu_ashr
    } alu_func_e;

    typedef enum logic [1:0] {alu2_b, alu2_four, alu2_sval} alu2_sel_e;
    typedef enum logic [1:0] {reg_alu, reg_b, reg_mdr, reg_imm} reg_sel_e;
    typedef enum logic [1:0] {mdr_hold, mdr_bus, mdr_alu, mdr_a} mdr_sel_e;
    typedef enum logic [1:0] {mar_hold, mar_alu} mar_sel_e;
    typedef enum logic [1:0] {pc_hold, pc_next, pc_rel, pc_alu} pc_sel_e;
    typedef enum logic {addr_pc, addr_mar} addr_sel_e;

    typedef enum logic [5:0] {
        s_reset, s_fetch, s_fetch2, s_eval, s_term, s_halt,
        s_inh, s_ldi, s_mov, s_mov2, s_cmp, s_cmp2, s_branch,
        s_alu, s_alu2, s_alu3, s_mdr2ra,
        s_load, s_load2, s_load3, s_load4,
        s_store, s_store2, s_store3, s_store4
    } state_e;

    // flags are {ltu, lt, eq}
    typedef enum logic [3:0] {
        bc_bra, bc_beq, bc_bne, bc_bgtu, bc_bgt, bc_bge,
        bc_ble, bc_blt, bc_bgeu, bc_bltu, bc_bleu, bc_brn
    } bra_cond_e;

endpackage

/* verilog/cpu_regfile.sv */
`timescale 1ns/10ps

module cpu_regfile import cpu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_addr_t read_addr1,
    input  reg_addr_t read_addr2,
    output word_t     read_data1,
    output word_t     read_data2,
    input  logic      write_en,
    input  reg_addr_t write_addr,
    input  word_t     write_data
);

    word_t regs [16];

    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

    // r0 is a normal register here
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_VECTOR = '0,
    parameter int    SHIFT_WIDTH  = 5
) (
    input  logic  clk_i,
    input  logic  rst_i,
    output logic  bus_cyc,
    output logic  bus_write,
    output word_t bus_adr,
    output word_t bus_dat_w,
    input  word_t bus_dat_r,
    input  logic  bus_ack,
    output logic  halt
);

    cpu_ctrl_if ctl_if ();

    cpu_control u_control (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ctl       (ctl_if.ctrl),
        .bus_cyc   (bus_cyc),
        .bus_write (bus_write),
        .bus_ack   (bus_ack),
        .halt      (halt)
    );

    cpu_datapath #(
        .RESET_VECTOR (RESET_VECTOR),
        .SHIFT_WIDTH  (SHIFT_WIDTH)
    ) u_datapath (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ctl       (ctl_if.dp),
        .bus_adr   (bus_adr),
        .bus_dat_w (bus_dat_w),
        .bus_dat_r (bus_dat_r),
        .bus_ack   (bus_ack)
    );

endmodule
